// ==== bus_pkg.sv ====
package bus_pkg;

    // Bus geometry
    localparam int num_masters = 4;
    localparam int master_id_w = 2;
    localparam int addr_w      = 32;
    localparam int num_devices = 5;

    // System address map, all windows inclusive and disjoint
    // RAM covers 8M x 16 bits
    localparam logic [addr_w-1:0] ram_low  = 32'h0000_0000;
    localparam logic [addr_w-1:0] ram_high = 32'h007F_FFFF;

    // ROM covers 8M x 16 bits
    localparam logic [addr_w-1:0] rom_low  = 32'h0080_0000;
    localparam logic [addr_w-1:0] rom_high = 32'h00FF_FFFF;

    // The three peripherals get 16 words each
    localparam logic [addr_w-1:0] vga_low  = 32'h0100_0000;
    localparam logic [addr_w-1:0] vga_high = 32'h0100_000F;

    localparam logic [addr_w-1:0] ps2_low  = 32'h0100_0010;
    localparam logic [addr_w-1:0] ps2_high = 32'h0100_001F;

    localparam logic [addr_w-1:0] acp_low  = 32'h0100_0020;
    localparam logic [addr_w-1:0] acp_high = 32'h0100_002F;

    // Device index, also the bit position in the one-hot enable
    typedef enum logic [2:0] {
        dev_ram = 3'd0,
        dev_rom = 3'd1,
        dev_vga = 3'd2,
        dev_ps2 = 3'd3,
        dev_acp = 3'd4
    } dev_id_e;

    // One access as a single master drives it
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } mst_access_t;

    // Access of the master that currently owns the bus
    typedef struct packed {
        logic                   valid;
        logic [master_id_w-1:0] master;
        logic [addr_w-1:0]      addr;
    } bus_access_t;

    // Access after window matching
    typedef struct packed {
        logic                   valid;
        logic                   hit;
        dev_id_e                dev;
        logic [master_id_w-1:0] master;
        logic [addr_w-1:0]      offset;
    } dec_access_t;

    // What the devices see, dev_en is the strobe
    typedef struct packed {
        logic [num_devices-1:0] dev_en;
        logic                   decode_err;
        logic [master_id_w-1:0] master;
        logic [addr_w-1:0]      offset;
    } dev_access_t;

endpackage

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [num_masters-1:0] req,
    input  mst_access_t            mst_in [num_masters],
    output logic [num_masters-1:0] ack,
    output bus_access_t            bus,
    output logic                   violation
);

    typedef enum logic {
        st_idle,
        st_busy
    } arb_state_e;

    arb_state_e             state;
    logic [master_id_w-1:0] owner;
    logic [master_id_w-1:0] winner;
    logic                   stray;
    logic                   violation_q;

    // Fixed priority, the lowest requesting index wins
    // Walking downwards lets the last assignment be the lowest index
    always_comb begin
        winner = '0;
        for (int i = num_masters - 1; i >= 0; i--) begin
            if (req[i]) begin
                winner = master_id_w'(i);
            end
        end
    end

    // The grant is taken only from idle, so a handover always
    // costs at least one cycle with no owner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            owner <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (|req) begin
                        state <= st_busy;
                        owner <= winner;
                    end
                end
                st_busy: begin
                    if (!req[owner]) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Acknowledge means ownership and follows the state register directly
    assign ack = (state == st_busy) ? (num_masters'(1) << owner) : '0;

    // Only the owner's strobe reaches the bus
    always_comb begin
        bus        = '0;
        bus.valid  = (state == st_busy) && mst_in[owner].valid;
        bus.master = owner;
        bus.addr   = mst_in[owner].addr;
    end

    // Any strobe from a master without the grant is a protocol error
    always_comb begin
        stray = 1'b0;
        for (int i = 0; i < num_masters; i++) begin
            if (mst_in[i].valid && !ack[i]) begin
                stray = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            violation_q <= 1'b0;
        end else begin
            violation_q <= stray;
        end
    end

    assign violation = violation_q;

    a_ack_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(ack)
    );

    // An owner is released to zero before anyone else is granted
    a_ack_handover: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ack != '0) |=> (ack == $past(ack)) || (ack == '0)
    );

endmodule

// ==== addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bus_access_t bus,
    output dec_access_t dec
);

    logic [num_devices-1:0] win_hit;
    logic                   hit_d;
    dev_id_e                dev_d;
    logic [addr_w-1:0]      offset_d;

    logic                   valid_q;
    logic                   hit_q;
    dev_id_e                dev_q;
    logic [master_id_w-1:0] master_q;
    logic [addr_w-1:0]      offset_q;

    function automatic logic in_window(
        input logic [addr_w-1:0] a,
        input logic [addr_w-1:0] lo,
        input logic [addr_w-1:0] hi
    );
        return (a >= lo) && (a <= hi);
    endfunction

    // One match flag per device is indexed by the device enumeration
    always_comb begin
        win_hit          = '0;
        win_hit[dev_ram] = in_window(bus.addr, ram_low, ram_high);
        win_hit[dev_rom] = in_window(bus.addr, rom_low, rom_high);
        win_hit[dev_vga] = in_window(bus.addr, vga_low, vga_high);
        win_hit[dev_ps2] = in_window(bus.addr, ps2_low, ps2_high);
        win_hit[dev_acp] = in_window(bus.addr, acp_low, acp_high);
    end

    // ROM is tested first and the rest follow in address order
    always_comb begin
        hit_d    = 1'b1;
        dev_d    = dev_ram;
        offset_d = '0;
        if (win_hit[dev_rom]) begin
            dev_d    = dev_rom;
            offset_d = bus.addr - rom_low;
        end else if (win_hit[dev_ram]) begin
            dev_d    = dev_ram;
            offset_d = bus.addr - ram_low;
        end else if (win_hit[dev_vga]) begin
            dev_d    = dev_vga;
            offset_d = bus.addr - vga_low;
        end else if (win_hit[dev_ps2]) begin
            dev_d    = dev_ps2;
            offset_d = bus.addr - ps2_low;
        end else if (win_hit[dev_acp]) begin
            dev_d    = dev_acp;
            offset_d = bus.addr - acp_low;
        end else begin
            hit_d = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bus.valid;
        end
    end

    // The payload registers load with each access and hold between accesses
    always_ff @(posedge clk) begin
        if (bus.valid) begin
            hit_q    <= hit_d;
            dev_q    <= dev_d;
            master_q <= bus.master;
            offset_q <= offset_d;
        end
    end

    assign dec = '{valid: valid_q, hit: hit_q, dev: dev_q, master: master_q, offset: offset_q};

    a_one_window: assert property (
        @(posedge clk) disable iff (!rst_n) bus.valid |-> $onehot0(win_hit)
    );

endmodule

// ==== device_select.sv ====
`timescale 1ns/1ps

module device_select
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dec_access_t dec,
    output dev_access_t out
);

    dev_access_t out_d;
    dev_access_t out_q;

    // A hit becomes a one-hot enable and a miss becomes the error strobe
    always_comb begin
        out_d = '0;
        if (dec.valid) begin
            out_d.master = dec.master;
            out_d.offset = dec.offset;
            if (dec.hit) begin
                out_d.dev_en = num_devices'(1) << dec.dev;
            end else begin
                out_d.decode_err = 1'b1;
            end
        end
    end

    // Everything clears between accesses, so each strobe lasts one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else begin
            out_q <= out_d;
        end
    end

    assign out = out_q;

    a_en_xor_err: assert property (
        @(posedge clk) disable iff (!rst_n) !((|out.dev_en) && out.decode_err)
    );

endmodule

// ==== bus_controller.sv ====
`timescale 1ns/1ps

module bus_controller
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [num_masters-1:0] req,
    input  mst_access_t            mst_in [num_masters],
    output logic [num_masters-1:0] ack,
    output dev_access_t            out,
    output logic                   violation
);

    // Owner's access, combinational from the arbiter
    bus_access_t bus_w;

    // Decoded access, one register stage later
    dec_access_t dec_w;

    bus_arbiter i_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .mst_in    (mst_in),
        .ack       (ack),
        .bus       (bus_w),
        .violation (violation)
    );

    addr_decoder i_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus_w),
        .dec   (dec_w)
    );

    // Second register stage drives the device strobes
    device_select i_select (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec_w),
        .out   (out)
    );

endmodule

// ==== tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Full output strobe of the bus, every field at once
task automatic check_access(input dev_access_t got, input dev_access_t exp);
    string msg;
    if (got !== exp) begin
        msg = {
            $sformatf("ERROR at time %0t: out en=%b err=%b mst=%0d off=%h,",
                      $time, got.dev_en, got.decode_err, got.master, got.offset),
            $sformatf(" expected en=%b err=%b mst=%0d off=%h",
                      exp.dev_en, exp.decode_err, exp.master, exp.offset)
        };
        abort_run(msg);
    end
endtask

// Ownership vector
task automatic check_ack(input logic [num_masters-1:0] got,
                         input logic [num_masters-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR at time %0t: ack=%b, expected %b", $time, got, exp));
    end
endtask

// Protocol violation strobe
task automatic check_violation(input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR at time %0t: violation=%b, expected %b",
                            $time, got, exp));
    end
endtask

// Number of cycles an ack change took
task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
        abort_run($sformatf("ERROR at time %0t: %s took %0d cycles, expected %0d",
                            $time, what, got, exp));
    end
endtask

`endif

// ==== tb_bus_controller.sv ====
`timescale 1ns/1ps

module tb_bus_controller
    import bus_pkg::*;
;

    localparam int max_vec     = 64;
    localparam int ack_timeout = 20;
    localparam int op_request  = 0;
    localparam int op_access   = 1;
    localparam int op_release  = 2;

    logic                   clk;
    logic                   rst_n;
    logic [num_masters-1:0] req;
    mst_access_t            mst_in [num_masters];
    logic [num_masters-1:0] ack;
    dev_access_t            out;
    logic                   violation;

    // Vectors from the data file
    int                op_a   [max_vec];
    int                mst_a  [max_vec];
    logic [addr_w-1:0] addr_a [max_vec];
    int                dev_a  [max_vec];
    logic [addr_w-1:0] off_a  [max_vec];
    bit                viol_a [max_vec];
    int                num_vec;

    // Strobes in flight and the cycle each must show up in
    int          out_due  [$];
    dev_access_t out_exp  [$];
    int          viol_due [$];
    int          cycle_cnt = 0;
    bit          checking  = 1'b0;
    dev_access_t exp_out;
    logic        exp_viol;
    int          owner = -1;

    bus_controller i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .mst_in    (mst_in),
        .ack       (ack),
        .out       (out),
        .violation (violation)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped");
    endtask

    `include "tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Outputs are sampled at the falling edge away from the drive slot
    always @(negedge clk) begin
        if (checking) begin
            exp_out = '0;
            if (out_due.size() != 0 && out_due[0] == cycle_cnt) begin
                exp_out = out_exp.pop_front();
                void'(out_due.pop_front());
            end
            check_access(out, exp_out);
            exp_viol = 1'b0;
            if (viol_due.size() != 0 && viol_due[0] == cycle_cnt) begin
                exp_viol = 1'b1;
                void'(viol_due.pop_front());
            end
            check_violation(violation, exp_viol);
        end
    end

    function automatic int lowest_req(input logic [num_masters-1:0] r);
        for (int k = 0; k < num_masters; k++) begin
            if (r[k]) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [num_masters-1:0] owner_ack(input int who);
        if (who < 0) begin
            return '0;
        end
        return num_masters'(1) << who;
    endfunction

    task automatic load_vectors();
        int                fd;
        int                n;
        string             op_s;
        string             dev_s;
        int                m_v;
        logic [addr_w-1:0] a_v;
        logic [addr_w-1:0] off_v;
        int                viol_v;
        fd = $fopen("bus_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open bus_input.txt for reading");
        end
        num_vec = 0;
        while (!$feof(fd) && num_vec < max_vec) begin
            n = $fscanf(fd, "%s %d %h %s %h %d\n", op_s, m_v, a_v, dev_s, off_v, viol_v);
            if (n == 6) begin
                if (op_s == "request") begin
                    op_a[num_vec] = op_request;
                end else if (op_s == "access") begin
                    op_a[num_vec] = op_access;
                end else if (op_s == "release") begin
                    op_a[num_vec] = op_release;
                end else begin
                    abort_run({"Unknown operation in bus_input.txt: ", op_s});
                end
                mst_a[num_vec]  = m_v;
                addr_a[num_vec] = a_v;
                dev_a[num_vec]  = (dev_s == "miss" || dev_s == "-") ? -1 : dev_s.atoi();
                off_a[num_vec]  = off_v;
                viol_a[num_vec] = (viol_v != 0);
                num_vec++;
            end else if (n > 0) begin
                abort_run($sformatf("Line %0d of bus_input.txt is malformed", num_vec + 1));
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_ack(input bit want_grant, output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
            if ((ack != '0) == want_grant) begin
                seen = 1'b1;
            end else if (cycles >= ack_timeout) begin
                abort_run($sformatf("Gave up after %0d cycles waiting for ack to %s",
                                    cycles, want_grant ? "rise" : "fall"));
            end
        end
    endtask

    // Each strobe lasts one cycle and the checker expects an out strobe
    // two cycles later or a violation one cycle later
    task automatic drive_access(input int idx);
        dev_access_t exp;
        for (int k = 0; k < num_masters; k++) begin
            mst_in[k] = '0;
        end
        mst_in[mst_a[idx]] = '{valid: 1'b1, addr: addr_a[idx]};
        if (viol_a[idx]) begin
            viol_due.push_back(cycle_cnt + 1);
        end else begin
            exp = '0;
            if (dev_a[idx] < 0) begin
                exp.decode_err = 1'b1;
            end else begin
                exp.dev_en = num_devices'(1) << dev_a[idx];
            end
            exp.master = master_id_w'(mst_a[idx]);
            exp.offset = off_a[idx];
            out_due.push_back(cycle_cnt + 2);
            out_exp.push_back(exp);
        end
    endtask

    initial begin
        int i;
        int gap;
        int cycles;
        int drain;
        rst_n = 1'b0;
        req   = '0;
        for (int k = 0; k < num_masters; k++) begin
            mst_in[k] = '0;
        end
        void'($urandom(6391));
        load_vectors();
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        checking = 1'b1;
        @(negedge clk);
        check_ack(ack, '0);
        @(posedge clk);
        #1;
        i = 0;
        while (i < num_vec) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            case (op_a[i])
                op_request: begin
                    // Consecutive requests are raised in the same cycle
                    while (i < num_vec && op_a[i] == op_request) begin
                        req[mst_a[i]] = 1'b1;
                        i++;
                    end
                    if (owner < 0) begin
                        owner = lowest_req(req);
                        wait_ack(1'b1, cycles);
                        check_latency(cycles, 1, "grant");
                    end else begin
                        @(posedge clk);
                        @(negedge clk);
                    end
                    check_ack(ack, owner_ack(owner));
                end
                op_release: begin
                    req[mst_a[i]] = 1'b0;
                    if (owner == mst_a[i]) begin
                        wait_ack(1'b0, cycles);
                        check_latency(cycles, 1, "release");
                        owner = lowest_req(req);
                        if (owner >= 0) begin
                            // One cycle with no owner before the next grant
                            wait_ack(1'b1, cycles);
                            check_latency(cycles, 1, "handover");
                            check_ack(ack, owner_ack(owner));
                        end
                    end else begin
                        @(posedge clk);
                        @(negedge clk);
                        check_ack(ack, owner_ack(owner));
                    end
                    i++;
                end
                default: begin
                    // Consecutive accesses go out back to back
                    while (i < num_vec && op_a[i] == op_access) begin
                        drive_access(i);
                        i++;
                        @(posedge clk);
                        #1;
                    end
                    for (int k = 0; k < num_masters; k++) begin
                        mst_in[k] = '0;
                    end
                end
            endcase
            @(posedge clk);
            #1;
        end
        drain = 0;
        while (out_due.size() != 0 || viol_due.size() != 0) begin
            @(posedge clk);
            #1;
            drain++;
            if (drain >= ack_timeout) begin
                abort_run("Expected output strobes never arrived within 20 cycles");
            end
        end
        repeat (2) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== bus_input.txt ====
request 1 00000000 - 00000000 0
access 1 00000000 0 00000000 0
access 1 007FFFFF 0 007FFFFF 0
access 1 00345678 0 00345678 0
release 1 00000000 - 00000000 0
request 3 00000000 - 00000000 0
request 2 00000000 - 00000000 0
request 0 00000000 - 00000000 0
access 0 00800000 1 00000000 0
access 0 00FFFFFF 1 007FFFFF 0
access 0 00A5A5A4 1 0025A5A4 0
access 2 01000000 - 00000000 1
release 0 00000000 - 00000000 0
access 2 01000000 2 00000000 0
access 2 0100000F 2 0000000F 0
access 2 01000007 2 00000007 0
access 3 01000010 - 00000000 1
release 2 00000000 - 00000000 0
access 3 01000010 3 00000000 0
access 3 0100001F 3 0000000F 0
access 3 01000018 3 00000008 0
access 3 01000020 4 00000000 0
access 3 0100002F 4 0000000F 0
access 3 01000024 4 00000004 0
access 3 01000030 miss 00000000 0
access 3 FFFFFFFF miss 00000000 0
access 3 01001000 miss 00000000 0
release 3 00000000 - 00000000 0
access 1 00000010 - 00000000 1
request 2 00000000 - 00000000 0
access 2 00400000 0 00400000 0
release 2 00000000 - 00000000 0

// ==== verilog.f ====
+incdir+.
bus_pkg.sv
bus_arbiter.sv
addr_decoder.sv
device_select.sv
bus_controller.sv
tb_bus_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bus controller testbench with Verilator and runs it

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_bus_controller

# The verdict comes from the simulation output, not from its exit status
sim_out=$(./obj_dir/Vtb_bus_controller 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1
